// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  localparam logic [11:0] csr_misa      = 12'h301;
  localparam logic [11:0] csr_mvendorid = 12'hF11;
  localparam logic [11:0] csr_marchid   = 12'hF12;
  localparam logic [11:0] csr_mimpid    = 12'hF13;
  localparam logic [11:0] csr_mhartid   = 12'hF14;
  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_mie       = 12'h304;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mscratch  = 12'h340;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mtval     = 12'h343;
  localparam logic [11:0] csr_mip       = 12'h344;
  localparam logic [11:0] csr_mcycle    = 12'hB00;
  localparam logic [11:0] csr_mcycleh   = 12'hB80;
  localparam logic [11:0] csr_minstret  = 12'hB02;
  localparam logic [11:0] csr_minstreth = 12'hB82;

  localparam logic [1:0] m_mode = 2'b11;
  localparam logic [1:0] u_mode = 2'b00;

  localparam logic [3:0] irq_mach_soft   = 4'd3;
  localparam logic [3:0] irq_mach_timer  = 4'd7;
  localparam logic [3:0] irq_mach_extern = 4'd11;

  typedef struct packed {
    logic       sd;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] mpp;
    logic       spp;
    logic       mpie;
    logic       spie;
    logic       upie;
    logic       mie;
    logic       sie;
    logic       uie;
  } mstatus_t;

  // same layout for mie and mip, bit 11 down to bit 0
  typedef struct packed {
    logic mext;
    logic rsvd_10;
    logic sext;
    logic uext;
    logic mtim;
    logic rsvd_6;
    logic stim;
    logic utim;
    logic msoft;
    logic rsvd_2;
    logic ssoft;
    logic usoft;
  } irq_bits_t;

  localparam logic [11:0] irq_write_mask = 12'hBBB; // reserved bits read zero
  localparam logic [11:0] mip_write_mask = 12'h333; // machine bits follow the lines

  typedef struct packed {
    logic        ren;
    logic [11:0] addr;
  } csr_read_in_t;

  typedef struct packed {
    logic        wen;
    logic [11:0] addr;
    logic [31:0] data;
  } csr_write_in_t;

  typedef struct packed {
    logic        valid; // instruction retires
    logic        exception;
    logic        mret;
    logic [31:0] epc;
    logic [31:0] etval;
    logic [3:0]  ecause;
  } csr_event_in_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        trap;
    logic        mret;
    logic [31:0] mepc;
    logic [31:0] trap_vector;
    logic [1:0]  fs;
  } csr_out_t;

  typedef struct packed {
    logic       take;
    logic       interrupt;
    logic [3:0] cause;
  } trap_decision_t;

  localparam mstatus_t mstatus_reset = '{mpp: m_mode, default: '0};

endpackage

`default_nettype wire

// ==== design/csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
  input  logic                   clock,
  input  logic                   reset,
  input  csr_pkg::csr_write_in_t write_in,
  input  logic                   retire,
  output logic [63:0]            mcycle,
  output logic [63:0]            minstret
);

  // index 0 is mcycle, index 1 is minstret
  localparam logic [1:0][11:0] lo_addr = {csr_pkg::csr_minstret, csr_pkg::csr_mcycle};
  localparam logic [1:0][11:0] hi_addr = {csr_pkg::csr_minstreth, csr_pkg::csr_mcycleh};

  logic [63:0] count [2];
  logic [1:0]  step;

  assign step = {retire, 1'b1};

  for (genvar i = 0; i < 2; i++) begin : g_count
    logic lo_wr;
    logic hi_wr;

    assign lo_wr = write_in.wen && (write_in.addr == lo_addr[i]);
    assign hi_wr = write_in.wen && (write_in.addr == hi_addr[i]);

    always_ff @(posedge clock) begin
      if (reset) begin
        count[i] <= '0;
      end else if (lo_wr) begin
        count[i][31:0] <= write_in.data; // write wins over the increment
      end else if (hi_wr) begin
        count[i][63:32] <= write_in.data;
      end else if (step[i]) begin
        count[i] <= count[i] + 64'd1;
      end
    end
  end

  assign mcycle   = count[0];
  assign minstret = count[1];

endmodule

`default_nettype wire

// ==== design/trap_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_control (
  input  logic                    clock,
  input  logic                    reset,
  input  csr_pkg::csr_event_in_t  event_in,
  input  logic                    global_ie,
  input  csr_pkg::irq_bits_t      enable,
  input  csr_pkg::irq_bits_t      pending,
  output csr_pkg::trap_decision_t decision,
  output logic                    trap,
  output logic                    mret
);

  csr_pkg::irq_bits_t active;
  logic               irq_ok;

  assign active = enable & pending;
  assign irq_ok = event_in.valid && global_ie; // interrupts only at retire

  always_comb begin
    decision = '0;
    if (event_in.exception) begin
      decision.take      = 1'b1;
      decision.interrupt = 1'b0;
      decision.cause     = event_in.ecause;
    end else if (irq_ok) begin
      if (active.mext) begin
        decision.take      = 1'b1;
        decision.interrupt = 1'b1;
        decision.cause     = csr_pkg::irq_mach_extern;
      end else if (active.mtim) begin
        decision.take      = 1'b1;
        decision.interrupt = 1'b1;
        decision.cause     = csr_pkg::irq_mach_timer;
      end else if (active.msoft) begin
        decision.take      = 1'b1;
        decision.interrupt = 1'b1;
        decision.cause     = csr_pkg::irq_mach_soft;
      end
    end
  end

  // one-cycle pulses after the trap or return edge
  always_ff @(posedge clock) begin
    if (reset) begin
      trap <= 1'b0;
      mret <= 1'b0;
    end else begin
      trap <= decision.take;
      mret <= event_in.mret;
    end
  end

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
  parameter logic [31:0] misa_value  = 32'h40001124,
  parameter logic [31:0] mtvec_reset = 32'h0
) (
  input  logic                    clock,
  input  logic                    reset,
  input  csr_pkg::csr_read_in_t   read_in,
  input  csr_pkg::csr_write_in_t  write_in,
  input  csr_pkg::csr_event_in_t  event_in,
  input  csr_pkg::trap_decision_t decision,
  input  logic                    meip,
  input  logic                    msip,
  input  logic                    mtip,
  input  logic [63:0]             mcycle,
  input  logic [63:0]             minstret,
  output logic                    global_ie,
  output csr_pkg::irq_bits_t      enable,
  output csr_pkg::irq_bits_t      pending,
  output logic [31:0]             rdata,
  output logic [31:0]             mepc,
  output logic [31:0]             trap_vector,
  output logic [1:0]              fs
);

  csr_pkg::mstatus_t  mstatus;
  csr_pkg::irq_bits_t mie;
  csr_pkg::irq_bits_t mip;
  logic [31:0]        mtvec;
  logic [31:0]        mscratch;
  logic [31:0]        mcause;
  logic [31:0]        mtval;
  logic [31:0]        mstatus_word;
  logic [31:0]        d;
  logic [31:0]        base;

  assign d = write_in.data;

  assign mstatus_word = {mstatus.sd, 8'h0, mstatus.tsr, mstatus.tw, mstatus.tvm,
                         mstatus.mxr, mstatus.sum, mstatus.mprv, mstatus.xs, mstatus.fs,
                         mstatus.mpp, 2'h0, mstatus.spp, mstatus.mpie, 1'h0, mstatus.spie,
                         mstatus.upie, mstatus.mie, 1'h0, mstatus.sie, mstatus.uie};

  always_comb begin
    rdata = '0;
    if (read_in.ren) begin
      case (read_in.addr)
        csr_pkg::csr_misa:      rdata = misa_value;
        csr_pkg::csr_mstatus:   rdata = mstatus_word;
        csr_pkg::csr_mie:       rdata = {20'h0, mie};
        csr_pkg::csr_mip:       rdata = {20'h0, mip};
        csr_pkg::csr_mtvec:     rdata = mtvec;
        csr_pkg::csr_mscratch:  rdata = mscratch;
        csr_pkg::csr_mepc:      rdata = mepc;
        csr_pkg::csr_mcause:    rdata = mcause;
        csr_pkg::csr_mtval:     rdata = mtval;
        csr_pkg::csr_mcycle:    rdata = mcycle[31:0];
        csr_pkg::csr_mcycleh:   rdata = mcycle[63:32];
        csr_pkg::csr_minstret:  rdata = minstret[31:0];
        csr_pkg::csr_minstreth: rdata = minstret[63:32];
        default:                rdata = '0; // vendor, arch, impl and hart ids too
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus  <= csr_pkg::mstatus_reset;
      mie      <= '0;
      mip      <= '0;
      mtvec    <= mtvec_reset;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      if (write_in.wen) begin
        case (write_in.addr)
          csr_pkg::csr_mstatus: begin
            mstatus <= '{sd: d[31], tsr: d[22], tw: d[21], tvm: d[20], mxr: d[19],
                         sum: d[18], mprv: d[17], xs: d[16:15], fs: d[14:13],
                         mpp: mstatus.mpp, spp: d[8], mpie: d[7], spie: d[5],
                         upie: d[4], mie: d[3], sie: d[1], uie: d[0]};
            if (d[12:11] == csr_pkg::m_mode || d[12:11] == csr_pkg::u_mode) begin
              mstatus.mpp <= d[12:11];
            end
          end
          csr_pkg::csr_mie:      mie <= d[11:0] & csr_pkg::irq_write_mask;
          csr_pkg::csr_mip:      mip <= d[11:0] & csr_pkg::mip_write_mask;
          csr_pkg::csr_mtvec:    mtvec <= d;
          csr_pkg::csr_mscratch: mscratch <= d;
          csr_pkg::csr_mepc:     mepc <= d;
          csr_pkg::csr_mcause:   mcause <= d;
          csr_pkg::csr_mtval:    mtval <= d;
          default: ;
        endcase
      end

      mip.mext  <= meip; // sampled every cycle
      mip.mtim  <= mtip;
      mip.msoft <= msip;

      if (decision.take) begin
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
        mepc         <= event_in.epc;
        mtval        <= event_in.etval;
        mcause       <= {decision.interrupt, 27'h0, decision.cause};
      end

      if (event_in.mret) begin
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b0;
      end
    end
  end

  assign base = {mtvec[31:2], 2'b00};

  always_comb begin
    if (mtvec[1:0] == 2'b01 && mcause[31]) begin
      trap_vector = base + {26'h0, mcause[3:0], 2'b00}; // vectored entry
    end else begin
      trap_vector = base;
    end
  end

  assign global_ie = mstatus.mie;
  assign enable    = mie;
  assign pending   = mip;
  assign fs        = mstatus.fs;

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
  parameter logic [31:0] misa_value  = 32'h40001124,
  parameter logic [31:0] mtvec_reset = 32'h0
) (
  input  logic                   clock,
  input  logic                   reset,
  input  csr_pkg::csr_read_in_t  read_in,
  input  csr_pkg::csr_write_in_t write_in,
  input  csr_pkg::csr_event_in_t event_in,
  input  logic                   meip,
  input  logic                   msip,
  input  logic                   mtip,
  output csr_pkg::csr_out_t      csr_out
);

  csr_pkg::trap_decision_t decision;
  csr_pkg::irq_bits_t      enable;
  csr_pkg::irq_bits_t      pending;
  logic                    global_ie;
  logic [63:0]             mcycle;
  logic [63:0]             minstret;
  logic                    trap;
  logic                    mret;
  logic [31:0]             rdata;
  logic [31:0]             mepc;
  logic [31:0]             trap_vector;
  logic [1:0]              fs;

  csr_counters i_counters (
    .clock    (clock),
    .reset    (reset),
    .write_in (write_in),
    .retire   (event_in.valid),
    .mcycle   (mcycle),
    .minstret (minstret)
  );

  trap_control i_trap_control (
    .clock     (clock),
    .reset     (reset),
    .event_in  (event_in),
    .global_ie (global_ie),
    .enable    (enable),
    .pending   (pending),
    .decision  (decision),
    .trap      (trap),
    .mret      (mret)
  );

  csr_file #(
    .misa_value  (misa_value),
    .mtvec_reset (mtvec_reset)
  ) i_file (
    .clock       (clock),
    .reset       (reset),
    .read_in     (read_in),
    .write_in    (write_in),
    .event_in    (event_in),
    .decision    (decision),
    .meip        (meip),
    .msip        (msip),
    .mtip        (mtip),
    .mcycle      (mcycle),
    .minstret    (minstret),
    .global_ie   (global_ie),
    .enable      (enable),
    .pending     (pending),
    .rdata       (rdata),
    .mepc        (mepc),
    .trap_vector (trap_vector),
    .fs          (fs)
  );

  assign csr_out.rdata       = rdata;
  assign csr_out.trap        = trap;
  assign csr_out.mret        = mret;
  assign csr_out.mepc        = mepc;
  assign csr_out.trap_vector = trap_vector;
  assign csr_out.fs          = fs;

endmodule

`default_nettype wire

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

  localparam int clock_period    = 8;
  localparam int cycles_per_case = 20;
  localparam int reset_cycles    = 8;

  logic                   clock;
  logic                   reset;
  logic                   meip;
  logic                   msip;
  logic                   mtip;
  csr_pkg::csr_read_in_t  read_in;
  csr_pkg::csr_write_in_t write_in;
  csr_pkg::csr_event_in_t event_in;
  csr_pkg::csr_out_t      csr_out;

  string       kind_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  logic [2:0]  irq_q [$];
  logic [31:0] value_q [$];
  int          line_q [$];
  int          case_count = 0;

  csr_unit i_dut (
    .clock    (clock),
    .reset    (reset),
    .read_in  (read_in),
    .write_in (write_in),
    .event_in (event_in),
    .meip     (meip),
    .msip     (msip),
    .mtip     (mtip),
    .csr_out  (csr_out)
  );

  initial clock = 1'b0;
  always #(clock_period / 2) clock = ~clock;

  task automatic stop_run(input string reason);
    $display("%0s", reason);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("Fail %0s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  // inputs change 1 ns after the edge and strobes drop unless set again
  task automatic advance_cycle();
    @(posedge clock);
    #1;
    read_in  = '0;
    write_in = '0;
    event_in = '0;
  endtask

  task automatic load_cases();
    int          fd;
    int          got;
    int          line_no;
    string       text;
    string       kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] irq;
    logic [31:0] v;
    fd = $fopen("verification/csr_cases.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the case file verification/csr_cases.txt");
    end else begin
      line_no = 0;
      while ($fgets(text, fd) != 0) begin
        line_no++;
        got = $sscanf(text, "%s %h %h %h %h", kind, a, d, irq, v);
        if (got == 5) begin // comment lines stop after the first token
          kind_q.push_back(kind);
          addr_q.push_back(a);
          data_q.push_back(d);
          irq_q.push_back(irq[2:0]);
          value_q.push_back(v);
          line_q.push_back(line_no);
        end
      end
      $fclose(fd);
      case_count = kind_q.size();
    end
  endtask

  task automatic check_trap_ends(input string name);
    advance_cycle();
    @(negedge clock);
    check_value({name, " trap end"}, 32'h0, {31'h0, csr_out.trap});
  endtask

  task automatic run_case(input int idx);
    string       kind;
    string       name;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] v;
    logic [31:0] epc;
    logic [31:0] etval;
    kind = kind_q[idx];
    a    = addr_q[idx];
    d    = data_q[idx];
    v    = value_q[idx];
    name = $sformatf("%0s line %0d", kind, line_q[idx]);
    advance_cycle();
    {meip, mtip, msip} = irq_q[idx];
    if (kind == "rd") begin
      read_in.ren  = 1'b1;
      read_in.addr = a[11:0];
      @(negedge clock);
      check_value(name, v, csr_out.rdata);
    end else if (kind == "wr") begin
      write_in.wen  = 1'b1;
      write_in.addr = a[11:0];
      write_in.data = d;
    end else if (kind == "idle") begin
      repeat (d - 1) advance_cycle();
    end else if (kind == "flags") begin
      @(negedge clock);
      check_value(name, v, {30'h0, csr_out.trap, csr_out.mret});
    end else if (kind == "vec") begin
      @(negedge clock);
      check_value(name, v, csr_out.trap_vector);
    end else if (kind == "fs") begin
      @(negedge clock);
      check_value(name, v, {30'h0, csr_out.fs});
    end else if (kind == "exc") begin
      epc   = d;
      etval = v;
      if (d == 0 && v == 0) begin
        epc   = $urandom();
        etval = $urandom();
      end
      event_in.exception = 1'b1;
      event_in.ecause    = a[3:0];
      event_in.epc       = epc;
      event_in.etval     = etval;
      @(negedge clock);
      check_value({name, " trap early"}, 32'h0, {31'h0, csr_out.trap});
      advance_cycle();
      read_in.ren  = 1'b1;
      read_in.addr = csr_pkg::csr_mtval;
      @(negedge clock);
      check_value({name, " trap"}, 32'h1, {31'h0, csr_out.trap});
      check_value({name, " mepc"}, epc, csr_out.mepc);
      check_value({name, " mtval"}, etval, csr_out.rdata);
      check_trap_ends(name);
    end else if (kind == "retire") begin
      event_in.valid = 1'b1;
      event_in.epc   = d;
      advance_cycle();
      @(negedge clock);
      check_value({name, " trap"}, v, {31'h0, csr_out.trap});
      if (v[0]) begin
        check_value({name, " mepc"}, d, csr_out.mepc);
      end
      check_trap_ends(name);
    end else if (kind == "ret") begin
      event_in.mret = 1'b1;
      advance_cycle();
      @(negedge clock);
      check_value({name, " mret"}, 32'h1, {31'h0, csr_out.mret});
      advance_cycle();
      @(negedge clock);
      check_value({name, " mret end"}, 32'h0, {31'h0, csr_out.mret});
    end else if (kind == "instr") begin
      event_in.valid = 1'b1;
      repeat (d - 1) begin
        advance_cycle();
        event_in.valid = 1'b1;
      end
    end else if (kind == "cyc") begin
      write_in.wen  = 1'b1;
      write_in.addr = csr_pkg::csr_mcycle;
      write_in.data = d;
      repeat (a) advance_cycle(); // address column holds the delay
      advance_cycle();
      read_in.ren  = 1'b1;
      read_in.addr = csr_pkg::csr_mcycle;
      @(negedge clock);
      check_value(name, v, csr_out.rdata);
    end else begin
      stop_run($sformatf("unknown operation %0s on line %0d", kind, line_q[idx]));
    end
  endtask

  initial begin
    void'($urandom(32'h795271a3));
    reset    = 1'b1;
    meip     = 1'b0;
    msip     = 1'b0;
    mtip     = 1'b0;
    read_in  = '0;
    write_in = '0;
    event_in = '0;
    load_cases();
    if (case_count == 0) begin
      stop_run("the case file holds no usable case lines");
    end else begin
      repeat (reset_cycles) @(posedge clock);
      #1;
      reset = 1'b0;
      for (int i = 0; i < case_count; i++) begin
        run_case(i);
      end
      advance_cycle();
      $display("All checks passed");
      $finish;
    end
  end

  initial begin
    int limit_ns;
    wait (case_count > 0);
    limit_ns = (case_count * cycles_per_case + reset_cycles) * clock_period;
    #(limit_ns);
    stop_run("the run timed out before all cases finished");
  end

endmodule

`default_nettype wire

// ==== verification/csr_cases.txt ====
# kind addr data irq expected with all numbers in hex
# irq is {meip mtip msip} and an exc with zero data and expected uses random epc and etval
flags 000 00000000 0 00000000
rd    301 00000000 0 40001124
rd    f11 00000000 0 00000000
rd    f12 00000000 0 00000000
rd    f13 00000000 0 00000000
rd    f14 00000000 0 00000000
rd    300 00000000 0 00001800
rd    7ff 00000000 0 00000000
wr    340 a5a5f00d 0 00000000
rd    340 00000000 0 a5a5f00d
wr    305 00001000 0 00000000
rd    305 00000000 0 00001000
wr    343 12345678 0 00000000
rd    343 00000000 0 12345678
wr    304 ffffffff 0 00000000
rd    304 00000000 0 00000bbb
wr    300 00002800 0 00000000
rd    300 00000000 0 00003800
fs    000 00000000 0 00000001
wr    300 00004000 0 00000000
rd    300 00000000 0 00004000
fs    000 00000000 0 00000002
wr    300 00001808 0 00000000
rd    300 00000000 0 00001808
exc   002 00000400 0 deadbeef
rd    342 00000000 0 00000002
rd    341 00000000 0 00000400
rd    300 00000000 0 00001880
vec   000 00000000 0 00001000
ret   000 00000000 0 00000000
rd    300 00000000 0 00001808
exc   005 00000000 0 00000000
rd    342 00000000 0 00000005
rd    300 00000000 0 00001880
ret   000 00000000 0 00000000
rd    300 00000000 0 00001808
idle  000 00000001 7 00000000
rd    344 00000000 7 00000888
retire 000 00000200 7 00000001
rd    342 00000000 7 8000000b
vec   000 00000000 7 00001000
ret   000 00000000 7 00000000
idle  000 00000001 3 00000000
retire 000 00000204 3 00000001
rd    342 00000000 3 80000007
ret   000 00000000 3 00000000
idle  000 00000001 1 00000000
retire 000 00000208 1 00000001
rd    342 00000000 1 80000003
wr    305 00001001 1 00000000
vec   000 00000000 1 0000100c
ret   000 00000000 1 00000000
wr    300 00001800 1 00000000
retire 000 0000020c 1 00000000
rd    300 00000000 1 00001800
idle  000 00000001 0 00000000
wr    b02 fffffffe 0 00000000
wr    b82 00000002 0 00000000
instr 000 00000003 0 00000000
rd    b02 00000000 0 00000001
rd    b82 00000000 0 00000003
cyc   005 00001000 0 00001005
cyc   000 0000beef 0 0000beef
flags 000 00000000 0 00000000

// ==== sim.f ====
design/csr_pkg.sv
design/csr_counters.sv
design/trap_control.sv
design/csr_file.sv
design/csr_unit.sv
verification/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module csr_unit_tb -o csr_sim
./obj_dir/csr_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without a reported failure"
